// File: verilog/isa_pkg.sv
//////////////////////////////
// isa_pkg
// opcodes, vectors, flag bits and selectors
// of the reduced 6809 instruction set
//////////////////////////////
package isa_pkg;
	localparam logic [7:0] OP_NOP      = 8'h12;
	localparam logic [7:0] OP_ANDCC    = 8'h1C;
	localparam logic [7:0] OP_LDA_IMM  = 8'h86;
	localparam logic [7:0] OP_ADDA_IMM = 8'h8B;
	localparam logic [7:0] OP_LDB_IMM  = 8'hC6;
	localparam logic [7:0] OP_ADDB_IMM = 8'hCB;
	localparam logic [7:0] OP_STA_EXT  = 8'hB7;
	localparam logic [7:0] OP_JMP_EXT  = 8'h7E;
	localparam logic [7:0] OP_PAGE2    = 8'h10;
	localparam logic [7:0] OP_LDS_IMM  = 8'hCE;	// second byte after OP_PAGE2

	localparam logic [15:0] VEC_RESET = 16'hFFFE;
	localparam logic [15:0] VEC_NMI   = 16'hFFFC;
	localparam logic [15:0] VEC_IRQ   = 16'hFFF8;
	localparam logic [15:0] VEC_FIRQ  = 16'hFFF6;

	localparam int CC_F = 6;
	localparam int CC_I = 4;
	localparam int CC_N = 3;
	localparam int CC_Z = 2;
	localparam int CC_V = 1;
	localparam int CC_C = 0;

	localparam logic [7:0] CC_RESET = 8'h50;	// interrupts masked

	typedef enum logic [1:0] {
		ALU_LD,
		ALU_ADD,
		ALU_AND
	} alu_op_t;

	typedef enum logic [2:0] {
		RS_NONE,
		RS_A,
		RS_B,
		RS_CC,
		RS_S
	} reg_sel_t;
endpackage

// File: verilog/bus_pkg.sv
//////////////////////////////
// bus_pkg
// memory bus, register control and register view records
//////////////////////////////
package bus_pkg;
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        oe;	// read strobe
		logic        we;	// write strobe
	} bus_out_t;

	typedef struct packed {
		isa_pkg::reg_sel_t dest;
		logic [15:0]       wr_data;
		logic              wr_flags;
		logic [7:0]        flags;
		logic              inc_pc;
		logic              load_pc;
		logic [15:0]       new_pc;
		logic              dec_s;
		logic              set_i;
		logic              set_f;
	} reg_ctrl_t;

	typedef struct packed {
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  cc;
		logic [15:0] pc;
		logic [15:0] s;
	} reg_view_t;

	typedef struct packed {
		logic nmi;
		logic firq;
		logic irq;
	} int_sel_t;
endpackage

// File: verilog/int_sync.sv
`timescale 1ns/1ns
//////////////////////////////
// int_sync
// synchronizes NMI, FIRQ and IRQ, masks them with
// F and I and picks one request by fixed priority
//////////////////////////////
module int_sync (
	input  logic              cpu_clk,
	input  logic              k_reset,
	input  logic              nmi_n_i,
	input  logic              firq_n_i,
	input  logic              irq_n_i,
	input  logic [7:0]        cc_i,
	input  logic              ack_i,
	output bus_pkg::int_sel_t sel_o
);
	import isa_pkg::*;

	logic [2:0] sync_q [3];	// 0 nmi, 1 firq, 2 irq
	logic [2:0] line;
	logic [2:0] req;
	logic [2:0] take;

	assign line = {~irq_n_i, ~firq_n_i, ~nmi_n_i};

	always_comb
	begin
		for (int i = 0; i < 3; i++)
			req[i] = sync_q[i][2] & sync_q[i][1];	// two oldest stages set
		take[0] = req[0];
		take[1] = req[1] & ~cc_i[CC_F] & ~take[0];
		take[2] = req[2] & ~cc_i[CC_I] & ~take[0] & ~take[1];
	end

	assign sel_o = '{nmi: take[0], firq: take[1], irq: take[2]};

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			for (int i = 0; i < 3; i++)
				sync_q[i] <= 3'b000;
		end
		else
		begin
			for (int i = 0; i < 3; i++)
			begin
				if (ack_i && take[i])
					sync_q[i] <= 3'b000;	// request served
				else if (!sync_q[i][2])
					sync_q[i] <= {sync_q[i][1:0], line[i]};
			end
		end
	end
endmodule

// File: verilog/alu8.sv
`timescale 1ns/1ns
//////////////////////////////
// alu8
// 8-bit load, add and and with condition codes
//////////////////////////////
module alu8 (
	input  isa_pkg::alu_op_t op_i,
	input  logic [7:0]       a_i,
	input  logic [7:0]       b_i,
	input  logic [7:0]       cc_i,
	output logic [7:0]       result_o,
	output logic [7:0]       cc_o
);
	import isa_pkg::*;

	logic [8:0] sum;

	assign sum = {1'b0, a_i} + {1'b0, b_i};

	always_comb
	begin
		cc_o = cc_i;
		case (op_i)
			ALU_ADD:
			begin
				result_o = sum[7:0];
				cc_o[CC_C] = sum[8];
				cc_o[CC_V] = (a_i[7] == b_i[7]) && (sum[7] != a_i[7]);	// signed overflow
			end
			ALU_AND:
			begin
				result_o = a_i & b_i;
				cc_o[CC_V] = 1'b0;
			end
			default:
			begin
				result_o = b_i;	// plain load
				cc_o[CC_V] = 1'b0;
			end
		endcase
		cc_o[CC_N] = result_o[7];
		cc_o[CC_Z] = (result_o == 8'h00);
	end
endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns
//////////////////////////////
// reg_file
// A, B, CC, PC and S with their update rules
//////////////////////////////
module reg_file (
	input  logic               cpu_clk,
	input  logic               k_reset,
	input  bus_pkg::reg_ctrl_t ctrl_i,
	output bus_pkg::reg_view_t view_o
);
	import isa_pkg::*;

	logic [7:0]  a_q;
	logic [7:0]  b_q;
	logic [7:0]  cc_q;
	logic [7:0]  cc_next;
	logic [15:0] pc_q;
	logic [15:0] s_q;

	// CC sources can stack up, set_i/set_f win last
	always_comb
	begin
		cc_next = cc_q;
		if (ctrl_i.dest == RS_CC)
			cc_next = ctrl_i.wr_data[7:0];
		if (ctrl_i.wr_flags)
			cc_next = ctrl_i.flags;
		if (ctrl_i.set_i)
			cc_next[CC_I] = 1'b1;
		if (ctrl_i.set_f)
			cc_next[CC_F] = 1'b1;
	end

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			a_q <= 8'h00;
			b_q <= 8'h00;
			cc_q <= CC_RESET;
			pc_q <= 16'h0000;
			s_q <= 16'h0000;
		end
		else
		begin
			if (ctrl_i.dest == RS_A)
				a_q <= ctrl_i.wr_data[7:0];
			if (ctrl_i.dest == RS_B)
				b_q <= ctrl_i.wr_data[7:0];
			cc_q <= cc_next;
			if (ctrl_i.load_pc)
				pc_q <= ctrl_i.new_pc;
			else if (ctrl_i.inc_pc)
				pc_q <= pc_q + 16'd1;
			if (ctrl_i.dest == RS_S)
				s_q <= ctrl_i.wr_data;	// full 16 bits
			else if (ctrl_i.dec_s)
				s_q <= s_q - 16'd1;
		end
	end

	assign view_o = '{a: a_q, b: b_q, cc: cc_q, pc: pc_q, s: s_q};
endmodule

// File: verilog/bus_sequencer.sv
`timescale 1ns/1ns
//////////////////////////////
// bus_sequencer
// reset vector, opcode and operand reads, store,
// jump and interrupt stacking on the byte bus
//////////////////////////////
module bus_sequencer (
	input  logic               cpu_clk,
	input  logic               k_reset,
	input  logic [7:0]         data_i,
	input  bus_pkg::reg_view_t view_i,
	input  logic [7:0]         alu_result_i,
	input  logic [7:0]         alu_cc_i,
	input  bus_pkg::int_sel_t  int_sel_i,
	output bus_pkg::bus_out_t  bus_o,
	output bus_pkg::reg_ctrl_t ctrl_o,
	output isa_pkg::alu_op_t   alu_op_o,
	output logic [7:0]         alu_a_o,
	output logic [7:0]         alu_b_o,
	output logic               int_ack_o
);
	import isa_pkg::*;
	import bus_pkg::*;

	typedef enum logic [3:0] {
		ST_RESET, ST_RD1, ST_RD2, ST_RD3, ST_DECODE, ST_WBACK,
		ST_NEXT, ST_STORE, ST_WRITE, ST_STACK, ST_VECTOR, ST_LOADPC
	} state_t;

	state_t     state;
	state_t     rd_ret;	// where a finished read goes
	logic       rd_pc;	// read address walks with PC
	logic       rd_left;	// second byte still to read
	logic       p2;	// page-2 prefix seen
	logic [1:0] stk_cnt;
	int_sel_t   int_src;
	logic [7:0] opcode;
	logic [7:0] mem_hi;
	logic [7:0] mem_lo;
	logic       fetching;
	logic       int_pend;

	assign fetching = (state == ST_RD1) && (rd_ret == ST_DECODE) && !p2;
	assign int_pend = int_sel_i.nmi | int_sel_i.firq | int_sel_i.irq;
	assign int_ack_o = fetching & int_pend;	// taken instead of the opcode read

	always_comb
	begin
		alu_op_o = ALU_LD;
		alu_a_o = view_i.a;
		case (opcode)
			OP_ANDCC:
			begin
				alu_op_o = ALU_AND;
				alu_a_o = view_i.cc;
			end
			OP_ADDA_IMM: alu_op_o = ALU_ADD;
			OP_ADDB_IMM:
			begin
				alu_op_o = ALU_ADD;
				alu_a_o = view_i.b;
			end
			default: ;
		endcase
	end

	assign alu_b_o = mem_lo;

	always_ff @(posedge cpu_clk)
	begin
		if (state == ST_RD3)
		begin
			mem_hi <= mem_lo;	// two reads leave hi:lo
			mem_lo <= data_i;
			if (rd_ret == ST_DECODE)
				opcode <= data_i;
		end
	end

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			state <= ST_RESET;
			rd_ret <= ST_DECODE;
			rd_pc <= 1'b0;
			rd_left <= 1'b0;
			p2 <= 1'b0;
			stk_cnt <= 2'd0;
			int_src <= '0;
			bus_o <= '0;
			ctrl_o <= '0;
		end
		else
		begin
			bus_o.oe <= 1'b0;	// strobes drop after one cycle
			bus_o.we <= 1'b0;
			ctrl_o.dest <= RS_NONE;
			ctrl_o.wr_flags <= 1'b0;
			ctrl_o.inc_pc <= 1'b0;
			ctrl_o.load_pc <= 1'b0;
			ctrl_o.dec_s <= 1'b0;
			ctrl_o.set_i <= 1'b0;
			ctrl_o.set_f <= 1'b0;
			case (state)
				ST_RESET:
				begin
					bus_o.addr <= VEC_RESET;
					rd_pc <= 1'b0;
					rd_left <= 1'b1;
					rd_ret <= ST_LOADPC;
					state <= ST_RD1;
				end
				ST_RD1:
				begin
					if (fetching && int_pend)
					begin
						int_src <= int_sel_i;
						stk_cnt <= 2'd0;
						state <= ST_STACK;
					end
					else
					begin
						bus_o.oe <= 1'b1;
						ctrl_o.inc_pc <= rd_pc;
						state <= ST_RD2;
					end
				end
				ST_RD2: state <= ST_RD3;
				ST_RD3:
				begin
					if (rd_ret == ST_DECODE && data_i == OP_PAGE2 && !p2)
					begin
						p2 <= 1'b1;
						bus_o.addr <= bus_o.addr + 16'd1;
						state <= ST_RD1;
					end
					else if (rd_left)
					begin
						rd_left <= 1'b0;
						bus_o.addr <= bus_o.addr + 16'd1;
						state <= ST_RD1;
					end
					else
					begin
						if (rd_ret == ST_LOADPC)
						begin
							ctrl_o.load_pc <= 1'b1;
							ctrl_o.new_pc <= {mem_lo, data_i};	// mem_lo still holds the high byte
						end
						state <= rd_ret;
					end
				end
				ST_DECODE:
				begin
					p2 <= 1'b0;
					bus_o.addr <= view_i.pc;
					rd_pc <= 1'b1;
					rd_left <= 1'b0;
					rd_ret <= ST_DECODE;	// unknown opcodes refetch
					state <= ST_RD1;
					if (p2 && opcode == OP_LDS_IMM)
					begin
						rd_left <= 1'b1;
						rd_ret <= ST_WBACK;
					end
					else if (!p2)
					begin
						case (opcode)
							OP_NOP: rd_ret <= ST_DECODE;
							OP_ANDCC, OP_LDA_IMM, OP_ADDA_IMM, OP_LDB_IMM, OP_ADDB_IMM:
								rd_ret <= ST_WBACK;
							OP_STA_EXT:
							begin
								rd_left <= 1'b1;
								rd_ret <= ST_STORE;
							end
							OP_JMP_EXT:
							begin
								rd_left <= 1'b1;
								rd_ret <= ST_LOADPC;
							end
							default: ;
						endcase
					end
				end
				ST_WBACK:
				begin
					ctrl_o.wr_data <= {8'h00, alu_result_i};
					ctrl_o.flags <= alu_cc_i;
					case (opcode)
						OP_ANDCC: ctrl_o.dest <= RS_CC;
						OP_LDA_IMM, OP_ADDA_IMM:
						begin
							ctrl_o.dest <= RS_A;
							ctrl_o.wr_flags <= 1'b1;
						end
						OP_LDB_IMM, OP_ADDB_IMM:
						begin
							ctrl_o.dest <= RS_B;
							ctrl_o.wr_flags <= 1'b1;
						end
						OP_LDS_IMM:
						begin
							ctrl_o.dest <= RS_S;
							ctrl_o.wr_data <= {mem_hi, mem_lo};
						end
						default: ;
					endcase
					state <= ST_NEXT;
				end
				ST_NEXT:
				begin
					bus_o.addr <= view_i.pc;
					rd_pc <= 1'b1;
					rd_left <= 1'b0;
					rd_ret <= ST_DECODE;
					state <= ST_RD1;
				end
				ST_STORE:
				begin
					bus_o.addr <= {mem_hi, mem_lo};
					bus_o.data <= view_i.a;
					bus_o.we <= 1'b1;
					state <= ST_WRITE;
				end
				ST_WRITE: state <= (int_src != '0) ? ST_STACK : ST_NEXT;
				ST_STACK:
				begin
					if (stk_cnt == 2'd3)
						state <= ST_VECTOR;
					else
					begin
						bus_o.addr <= view_i.s - 16'd1;
						case (stk_cnt)
							2'd0: bus_o.data <= view_i.pc[7:0];
							2'd1: bus_o.data <= view_i.pc[15:8];
							default: bus_o.data <= view_i.cc;	// CC before masking
						endcase
						bus_o.we <= 1'b1;
						ctrl_o.dec_s <= 1'b1;
						stk_cnt <= stk_cnt + 2'd1;
						state <= ST_WRITE;
					end
				end
				ST_VECTOR:
				begin
					ctrl_o.set_i <= 1'b1;
					ctrl_o.set_f <= int_src.nmi | int_src.firq;
					if (int_src.nmi)
						bus_o.addr <= VEC_NMI;
					else if (int_src.firq)
						bus_o.addr <= VEC_FIRQ;
					else
						bus_o.addr <= VEC_IRQ;
					int_src <= '0;
					rd_pc <= 1'b0;
					rd_left <= 1'b1;
					rd_ret <= ST_LOADPC;
					state <= ST_RD1;
				end
				ST_LOADPC:
				begin
					bus_o.addr <= ctrl_o.new_pc;	// PC itself lands at this edge
					rd_pc <= 1'b1;
					rd_left <= 1'b0;
					rd_ret <= ST_DECODE;
					state <= ST_RD1;
				end
				default: state <= ST_RESET;
			endcase
		end
	end
endmodule

// File: verilog/cpu6809_lite.sv
`timescale 1ns/1ns
//////////////////////////////
// cpu6809_lite
// reduced 6809 core, sequencer plus registers,
// ALU and interrupt synchronizer
//////////////////////////////
module cpu6809_lite (
	input  logic              cpu_clk,
	input  logic              k_reset,
	input  logic              nmi_n_i,
	input  logic              firq_n_i,
	input  logic              irq_n_i,
	output bus_pkg::bus_out_t bus_o,
	input  logic [7:0]        data_i,
	output logic [7:0]        cc_o
);
	import isa_pkg::*;
	import bus_pkg::*;

	reg_view_t  view;
	reg_ctrl_t  ctrl;
	int_sel_t   int_sel;
	logic       int_ack;
	alu_op_t    alu_op;
	logic [7:0] alu_a;
	logic [7:0] alu_b;
	logic [7:0] alu_result;
	logic [7:0] alu_cc;

	assign cc_o = view.cc;

	int_sync u_int_sync (
		.cpu_clk (cpu_clk),
		.k_reset (k_reset),
		.nmi_n_i (nmi_n_i),
		.firq_n_i(firq_n_i),
		.irq_n_i (irq_n_i),
		.cc_i    (view.cc),
		.ack_i   (int_ack),
		.sel_o   (int_sel)
	);

	alu8 u_alu8 (
		.op_i    (alu_op),
		.a_i     (alu_a),
		.b_i     (alu_b),
		.cc_i    (view.cc),
		.result_o(alu_result),
		.cc_o    (alu_cc)
	);

	reg_file u_reg_file (
		.cpu_clk(cpu_clk),
		.k_reset(k_reset),
		.ctrl_i (ctrl),
		.view_o (view)
	);

	bus_sequencer u_bus_sequencer (
		.cpu_clk     (cpu_clk),
		.k_reset     (k_reset),
		.data_i      (data_i),
		.view_i      (view),
		.alu_result_i(alu_result),
		.alu_cc_i    (alu_cc),
		.int_sel_i   (int_sel),
		.bus_o       (bus_o),
		.ctrl_o      (ctrl),
		.alu_op_o    (alu_op),
		.alu_a_o     (alu_a),
		.alu_b_o     (alu_b),
		.int_ack_o   (int_ack)
	);
endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ns
//////////////////////////////
// tb_clock
// cpu_clk at 8 ns and a 3-cycle k_reset
//////////////////////////////
module tb_clock (
	output logic cpu_clk_o,
	output logic k_reset_o
);
	initial
	begin
		cpu_clk_o = 1'b0;
		k_reset_o = 1'b1;
		repeat (3) @(posedge cpu_clk_o);
		#1 k_reset_o = 1'b0;
	end

	always #4 cpu_clk_o = ~cpu_clk_o;
endmodule

// File: testbench/tb_top.sv
`timescale 1ns/1ns
//////////////////////////////
// tb_top
// memory model and directed tests for cpu6809_lite
//////////////////////////////
module tb_top;
	import isa_pkg::*;
	import bus_pkg::*;

	logic        cpu_clk;
	logic        k_reset;
	logic        nmi_n;
	logic        firq_n;
	logic        irq_n;
	bus_out_t    bus;
	logic [7:0]  data;
	logic [7:0]  cc;
	logic [7:0]  mem [65536];
	logic [15:0] rd_q [$];	// addresses of oe cycles
	logic [23:0] wr_q [$];	// {addr, data} of we cycles
	int          cycles;
	int          seed;

	tb_clock u_clock (.cpu_clk_o(cpu_clk), .k_reset_o(k_reset));

	cpu6809_lite dut0 (
		.cpu_clk (cpu_clk),
		.k_reset (k_reset),
		.nmi_n_i (nmi_n),
		.firq_n_i(firq_n),
		.irq_n_i (irq_n),
		.bus_o   (bus),
		.data_i  (data),
		.cc_o    (cc)
	);

	assign data = mem[bus.addr];

	always @(posedge cpu_clk)
	begin
		if (bus.we)
		begin
			mem[bus.addr] = bus.data;
			wr_q.push_back({bus.addr, bus.data});
		end
		if (bus.oe)
			rd_q.push_back(bus.addr);
		cycles = cycles + 1;
		if (cycles >= 3000)
		begin
			$display("timeout: the run went past its limit of 3000 cycles");
			$display("CHECKS FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic check_eq(input logic [31:0] exp, input logic [31:0] act, input string msg);
		if (exp !== act)
		begin
			$display("Fail at %0t ns: %s, expected %h got %h", $time, msg, exp, act);
			$display("CHECKS FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic tick();
		@(posedge cpu_clk);
		#1;
	endtask

	task automatic next_read(output logic [15:0] addr);
		while (rd_q.size() == 0)
			tick();
		addr = rd_q.pop_front();
	endtask

	task automatic skip_to_read(input logic [15:0] target);
		logic [15:0] a;
		a = 16'h0000;
		next_read(a);
		while (a != target)
			next_read(a);
	endtask

	task automatic poke(input logic [15:0] addr, input logic [7:0] val);
		mem[addr] = val;
	endtask

	// redirect the park loop at 0100 to a program, then restore it
	task automatic launch(input logic [15:0] start);
		rd_q.delete();
		skip_to_read(16'h0100);
		poke(16'h0101, start[15:8]);
		poke(16'h0102, start[7:0]);
		skip_to_read(start);
		poke(16'h0101, 8'h01);
		poke(16'h0102, 8'h00);
	endtask

	// flags of an 8-bit add from the integer sums
	function automatic logic [7:0] add_flags(input logic [7:0] x, input logic [7:0] y);
		int         u;
		int         s;
		logic [7:0] f;
		u = int'(x) + int'(y);
		s = int'($signed(x)) + int'($signed(y));
		f = 8'h50;	// I and F stay set
		f[CC_N] = (u % 256) >= 128;
		f[CC_Z] = (u % 256) == 0;
		f[CC_V] = (s > 127) || (s < -128);
		f[CC_C] = u > 255;
		return f;
	endfunction

	task automatic reset_vector_reads();
		logic [15:0] a;
		next_read(a);
		check_eq(16'hFFFE, a, "first vector read");
		next_read(a);
		check_eq(16'hFFFF, a, "second vector read");
		next_read(a);
		check_eq(16'h0100, a, "first opcode read");
	endtask

	task automatic load_add_store();
		logic [7:0]  x;
		logic [7:0]  y;
		logic [7:0]  x2;
		logic [7:0]  y2;
		logic [23:0] w;
		for (int k = 0; k < 8; k++)
		begin
			x = 8'($urandom);
			y = 8'($urandom);
			x2 = 8'($urandom);
			y2 = 8'($urandom);
			poke(16'h0200, OP_LDA_IMM);
			poke(16'h0201, x);
			poke(16'h0202, OP_ADDA_IMM);
			poke(16'h0203, y);
			poke(16'h0204, OP_STA_EXT);
			poke(16'h0205, 8'h03);
			poke(16'h0206, 8'h00);
			poke(16'h0207, OP_LDB_IMM);
			poke(16'h0208, x2);
			poke(16'h0209, OP_ADDB_IMM);
			poke(16'h020A, y2);
			poke(16'h020B, OP_JMP_EXT);
			poke(16'h020C, 8'h01);
			poke(16'h020D, 8'h00);
			wr_q.delete();
			launch(16'h0200);
			while (wr_q.size() == 0)
				tick();
			w = wr_q.pop_front();
			check_eq(16'h0300, w[23:8], "STA address");
			check_eq(8'(x + y), w[7:0], "STA data");
			check_eq(add_flags(x, y), cc, "CC after ADDA");
			skip_to_read(16'h0100);
			check_eq(0, wr_q.size(), "extra writes");
			check_eq(add_flags(x2, y2), cc, "CC after ADDB");
		end
	endtask

	task automatic jump_to_target();
		logic [15:0] a;
		poke(16'h0220, OP_JMP_EXT);
		poke(16'h0221, 8'h02);
		poke(16'h0222, 8'h40);
		poke(16'h0240, OP_JMP_EXT);
		poke(16'h0241, 8'h01);
		poke(16'h0242, 8'h00);
		launch(16'h0220);
		next_read(a);
		next_read(a);
		next_read(a);
		check_eq(16'h0240, a, "fetch at jump target");
		skip_to_read(16'h0100);
	endtask

	task automatic irq_mask_entry();
		logic [15:0] a;
		logic [7:0]  cc_before;
		logic [23:0] w;
		poke(16'h0400, OP_PAGE2);
		poke(16'h0401, OP_LDS_IMM);
		poke(16'h0402, 8'h08);
		poke(16'h0403, 8'h00);
		for (int i = 0; i < 4; i++)
			poke(16'(16'h0404 + i), OP_NOP);
		poke(16'h0408, OP_ANDCC);
		poke(16'h0409, 8'hEF);	// clears I
		poke(16'h040A, OP_NOP);
		poke(16'h040B, OP_JMP_EXT);
		poke(16'h040C, 8'h01);
		poke(16'h040D, 8'h00);
		cc_before = cc;
		irq_n = 1'b0;
		wr_q.delete();
		launch(16'h0400);
		skip_to_read(16'h0408);
		check_eq(0, wr_q.size(), "stack write while I set");
		irq_n = 1'b1;	// request is already latched
		next_read(a);
		check_eq(16'h0409, a, "ANDCC operand read");
		next_read(a);
		check_eq(16'hFFF8, a, "IRQ vector high");
		next_read(a);
		check_eq(16'hFFF9, a, "IRQ vector low");
		next_read(a);
		check_eq(16'h0500, a, "fetch at IRQ handler");
		check_eq(3, wr_q.size(), "IRQ stack write count");
		w = wr_q.pop_front();
		check_eq({16'h07FF, 8'h0A}, w, "stacked PC low");
		w = wr_q.pop_front();
		check_eq({16'h07FE, 8'h04}, w, "stacked PC high");
		w = wr_q.pop_front();
		check_eq({16'h07FD, cc_before & 8'hEF}, w, "stacked CC");
		check_eq(8'h10, cc & 8'h10, "I set after IRQ entry");
		skip_to_read(16'h0100);
	endtask

	task automatic nmi_priority_firq_mask();
		logic [15:0] a;
		poke(16'h0600, OP_ANDCC);
		poke(16'h0601, 8'hAF);	// clears I and F
		poke(16'h0602, OP_JMP_EXT);
		poke(16'h0603, 8'h06);
		poke(16'h0604, 8'h02);
		wr_q.delete();
		launch(16'h0600);
		skip_to_read(16'h0602);
		nmi_n = 1'b0;
		irq_n = 1'b0;
		repeat (3) tick();
		nmi_n = 1'b1;
		irq_n = 1'b1;
		next_read(a);
		while (a[15:8] != 8'hFF)
			next_read(a);
		check_eq(16'hFFFC, a, "NMI wins vector");
		next_read(a);
		check_eq(16'hFFFD, a, "NMI vector low");
		next_read(a);
		check_eq(16'h0700, a, "fetch at NMI handler");
		check_eq(3, wr_q.size(), "NMI stack write count");
		check_eq(8'h00, wr_q[2][7:0] & 8'h50, "stacked CC has I and F clear");
		check_eq(8'h50, cc & 8'h50, "I and F set after NMI");
		skip_to_read(16'h0100);
		// F is set now, so FIRQ stays masked
		wr_q.delete();
		firq_n = 1'b0;
		repeat (3) tick();
		firq_n = 1'b1;
		repeat (40) tick();
		check_eq(0, wr_q.size(), "stack write on masked FIRQ");
	endtask

	initial
	begin
		nmi_n = 1'b1;
		firq_n = 1'b1;
		irq_n = 1'b1;
		cycles = 0;
		seed = $urandom(15);
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i[15:8] ^ i[7:0]);
		poke(16'hFFFE, 8'h01);	// reset to park loop
		poke(16'hFFFF, 8'h00);
		poke(16'hFFF8, 8'h05);
		poke(16'hFFF9, 8'h00);
		poke(16'hFFFC, 8'h07);
		poke(16'hFFFD, 8'h00);
		poke(16'hFFF6, 8'h07);
		poke(16'hFFF7, 8'h00);
		poke(16'h0100, OP_JMP_EXT);
		poke(16'h0101, 8'h01);
		poke(16'h0102, 8'h00);
		poke(16'h0500, OP_JMP_EXT);
		poke(16'h0501, 8'h01);
		poke(16'h0502, 8'h00);
		poke(16'h0700, OP_JMP_EXT);
		poke(16'h0701, 8'h01);
		poke(16'h0702, 8'h00);
		reset_vector_reads();
		load_add_store();
		jump_to_target();
		irq_mask_entry();
		nmi_priority_firq_mask();
		$display("ALL CHECKS PASSED");
		$finish;
	end
endmodule

// File: tb.f
verilog/isa_pkg.sv
verilog/bus_pkg.sv
verilog/int_sync.sv
verilog/alu8.sv
verilog/reg_file.sv
verilog/bus_sequencer.sv
verilog/cpu6809_lite.sv
testbench/tb_clock.sv
testbench/tb_top.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_top
FILELIST  = tb.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
